// File: hdl/dac_pkg.sv
`default_nettype none

package dac_pkg;

	// DAC data bus and sample scaling
	localparam int dac_w        = 10;
	localparam int sample_shift = 2;

	// ----------------------------------------
	// Sample rate generation
	// ----------------------------------------
	localparam int div_w        = 8;
	localparam int n_phase      = 4;

	// Power-on counter and its sync count
	localparam int sync_cnt_w   = 4;
	localparam int sync_point   = 14;

	// Slope limit width
	localparam int slope_w      = 14;

endpackage

`default_nettype wire

// File: hdl/dac_set_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dac_set_regs
	import wave_pkg::*;
#(
	parameter int n_ch = 4
)
(
	input  wire logic                              clk,
	input  wire logic                              rstn,
	input  wire logic                              da_set_wren,
	input  wire logic [host_word_w-1:0]            set_word,
	input  wire logic [host_word_w-1:0]            wave_addr,
	input  wire logic                              wave_wren,
	output logic      [n_ch-1:0][set_value_w-1:0]  set_value,
	output logic      [n_ch-1:0]                   chan_wren
);

	// Channel fields of the two host words
	logic [chan_sel_w-1:0] set_chan;
	logic [chan_sel_w-1:0] wave_chan;

	assign set_chan  = set_word[chan_sel_lsb +: chan_sel_w];
	assign wave_chan = wave_addr[chan_sel_lsb +: chan_sel_w];

	// ----------------------------------------
	// Static value registers
	// ----------------------------------------
	// Channel numbers past n_ch match no register
	always_ff @(posedge clk)
	begin
		if (!rstn)
			set_value <= '0;
		else if (da_set_wren)
		begin
			for (int i = 0; i < n_ch; i++)
			begin
				if (set_chan == chan_sel_w'(i))
					set_value[i] <= set_word[set_value_w-1:0];
			end
		end
	end

	// ----------------------------------------
	// Memory write decode
	// ----------------------------------------
	// At most one channel strobed per host write
	always_comb
	begin
		for (int i = 0; i < n_ch; i++)
			chan_wren[i] = wave_wren && (wave_chan == chan_sel_w'(i));
	end

endmodule

`default_nettype wire

// File: hdl/dac_sync_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dac_sync_gen
	import dac_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rstn,
	input  wire logic [div_w-1:0]  div_cnt,
	output logic      [n_phase-1:0] phase_tick
);

	logic [sync_cnt_w-1:0] pwr_cnt;
	logic                  sync_hit;
	logic                  div_run;
	logic [div_w-1:0]      div_q;

	// ----------------------------------------
	// Power-on sync
	// ----------------------------------------
	// Counts up once after reset and parks at all ones
	always_ff @(posedge clk)
	begin
		if (!rstn)
			pwr_cnt <= '0;
		else if (pwr_cnt != '1)
			pwr_cnt <= pwr_cnt + 1'b1;
	end

	// Single hit since the counter never wraps
	assign sync_hit = (pwr_cnt == sync_cnt_w'(sync_point));

	// Sample divider 0..div_cnt
	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			div_run <= 1'b0;
			div_q   <= '0;
		end
		else if (sync_hit)
		begin
			div_run <= 1'b1;
			div_q   <= '0;
		end
		else if (div_run)
			div_q <= (div_q == div_cnt) ? '0 : div_q + 1'b1;
	end

	// Slot p fires when the divider sits at p
	always_comb
	begin
		for (int p = 0; p < n_phase; p++)
			phase_tick[p] = div_run && (div_q == div_w'(p));
	end

endmodule

`default_nettype wire

// File: hdl/dac_wave_top.sv
`timescale 1ns/1ps
`default_nettype none

module dac_wave_top
	import wave_pkg::*;
	import dac_pkg::*;
#(
	parameter int n_ch = 4
)
(
	input  wire logic                                clk,
	input  wire logic                                rstn,
	input  wire logic [div_w-1:0]                    div_cnt,
	input  wire logic                                da_set_en,
	input  wire logic                                da_set_wren,
	input  wire logic [host_word_w-1:0]              set_word,
	input  wire logic [dac_w-1:0]                    vol_max,
	input  wire logic [slope_w-1:0]                  slope_max,
	input  wire logic [n_ch-1:0]                     wave_req,
	input  wire logic [n_ch-1:0][ram_addr_w-1:0]     start_addr,
	input  wire logic [host_word_w-1:0]              wave_addr,
	input  wire logic [sample_w-1:0]                 wave_data,
	input  wire logic                                wave_wren,
	output logic      [n_ch-1:0]                     wave_end,
	output logic      [n_ch-1:0]                     vol_err,
	output logic      [n_ch-1:0]                     slope_err,
	output logic      [n_ch-1:0]                     da_dclk,
	output logic      [n_ch-1:0][dac_w-1:0]          da_data
);

	// Per-channel static values and memory write strobes
	logic [n_ch-1:0][set_value_w-1:0] set_value;
	logic [n_ch-1:0]                  chan_wren;

	// One sample strobe per phase slot
	logic [n_phase-1:0]               phase_tick;

	// ----------------------------------------
	// Host configuration
	// ----------------------------------------
	dac_set_regs #(
		.n_ch        (n_ch)
	) set_regs_i (
		.clk         (clk),
		.rstn        (rstn),
		.da_set_wren (da_set_wren),
		.set_word    (set_word),
		.wave_addr   (wave_addr),
		.wave_wren   (wave_wren),
		.set_value   (set_value),
		.chan_wren   (chan_wren)
	);

	// Shared divider with phase-staggered strobes
	dac_sync_gen sync_gen_i (
		.clk         (clk),
		.rstn        (rstn),
		.div_cnt     (div_cnt),
		.phase_tick  (phase_tick)
	);

	// ----------------------------------------
	// Channels
	// ----------------------------------------
	// Channel i runs on slot i mod n_phase
	for (genvar i = 0; i < n_ch; i++)
	begin : g_chan
		wave_channel chan_i (
			.clk        (clk),
			.rstn       (rstn),
			.tick       (phase_tick[i % n_phase]),
			.wave_req   (wave_req[i]),
			.start_addr (start_addr[i]),
			.wr_addr    (wave_addr[ram_addr_w-1:0]),
			.wr_data    (wave_data),
			.wr_en      (chan_wren[i]),
			.da_set_en  (da_set_en),
			.set_value  (set_value[i]),
			.vol_max    (vol_max),
			.slope_max  (slope_max),
			.wave_end   (wave_end[i]),
			.vol_err    (vol_err[i]),
			.slope_err  (slope_err[i]),
			.da_dclk    (da_dclk[i]),
			.da_data    (da_data[i])
		);
	end

endmodule

`default_nettype wire

// File: hdl/limit_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module limit_monitor
	import dac_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rstn,
	input  wire logic               load,
	input  wire logic               clear,
	input  wire logic [dac_w-1:0]   value,
	input  wire logic [dac_w-1:0]   vol_max,
	input  wire logic [slope_w-1:0] slope_max,
	output logic                    vol_err,
	output logic                    slope_err
);

	// Last loaded value and whether one exists yet
	logic [dac_w-1:0] prev;
	logic             have_prev;
	logic [dac_w-1:0] step;

	// Absolute step from the previous load
	assign step = (value >= prev) ? value - prev : prev - value;

	always_ff @(posedge clk)
	begin
		prev <= load ? value : prev;
	end

	// ----------------------------------------
	// Sticky flags
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstn || clear)
		begin
			have_prev <= 1'b0;
			vol_err   <= 1'b0;
			slope_err <= 1'b0;
		end
		else if (load)
		begin
			have_prev <= 1'b1;
			if (value > vol_max)
				vol_err <= 1'b1;
			// No step check on the first sample
			if (have_prev && (slope_w'(step) > slope_max))
				slope_err <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/wave_channel.sv
`timescale 1ns/1ps
`default_nettype none

module wave_channel
	import wave_pkg::*;
	import dac_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rstn,
	input  wire logic                   tick,
	input  wire logic                   wave_req,
	input  wire logic [ram_addr_w-1:0]  start_addr,
	input  wire logic [ram_addr_w-1:0]  wr_addr,
	input  wire logic [sample_w-1:0]    wr_data,
	input  wire logic                   wr_en,
	input  wire logic                   da_set_en,
	input  wire logic [set_value_w-1:0] set_value,
	input  wire logic [dac_w-1:0]       vol_max,
	input  wire logic [slope_w-1:0]     slope_max,
	output logic                        wave_end,
	output logic                        vol_err,
	output logic                        slope_err,
	output logic                        da_dclk,
	output logic      [dac_w-1:0]       da_data
);

	// Sequencer state
	logic                  playing;
	logic [ram_addr_w-1:0] rd_addr;
	logic [sample_w-1:0]   rd_data;

	// Stage 1 beside the memory read
	logic                  s1_vld;
	logic                  s1_play;
	logic                  s1_last;

	// Stage 2 load and scaled sample
	logic                  load_out;
	logic [dac_w-1:0]      scaled;

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	// A request restarts from start_addr even mid-playback
	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			playing <= 1'b0;
			rd_addr <= '0;
		end
		else if (wave_req)
		begin
			playing <= 1'b1;
			rd_addr <= start_addr;
		end
		else if (tick && playing)
		begin
			rd_addr <= rd_addr + 1'b1;
			// Last address just issued
			if (rd_addr == '1)
				playing <= 1'b0;
		end
	end

	wave_ram ram_i (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// ----------------------------------------
	// Output pipeline
	// ----------------------------------------
	// Idle ticks only count with da_set_en high
	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			s1_vld  <= 1'b0;
			s1_play <= 1'b0;
			s1_last <= 1'b0;
		end
		else
		begin
			s1_vld  <= tick && !wave_req && (playing || da_set_en);
			s1_play <= playing;
			s1_last <= (rd_addr == '1);
		end
	end

	// Request flushes anything still in flight
	assign load_out = s1_vld && !wave_req;
	assign scaled   = dac_w'(rd_data) << sample_shift;

	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			da_dclk  <= 1'b0;
			wave_end <= 1'b0;
			da_data  <= '0;
		end
		else
		begin
			da_dclk  <= load_out;
			wave_end <= load_out && s1_play && s1_last;
			if (load_out)
				da_data <= s1_play ? scaled : dac_w'(set_value);
		end
	end

	// Checks see only played samples
	limit_monitor limit_i (
		.clk       (clk),
		.rstn      (rstn),
		.load      (load_out && s1_play),
		.clear     (wave_req),
		.value     (scaled),
		.vol_max   (vol_max),
		.slope_max (slope_max),
		.vol_err   (vol_err),
		.slope_err (slope_err)
	);

endmodule

`default_nettype wire

// File: hdl/wave_pkg.sv
`default_nettype none

package wave_pkg;

	// ----------------------------------------
	// Host words
	// ----------------------------------------

	// Address word and set word share one width
	localparam int host_word_w  = 16;

	// Channel number sits in the top field
	localparam int chan_sel_lsb = 10;
	localparam int chan_sel_w   = 6;

	// Static value in the low bits of a set word
	localparam int set_value_w  = 10;

	// ----------------------------------------
	// Sample memory
	// ----------------------------------------
	localparam int ram_addr_w   = 8;
	localparam int sample_w     = 8;

endpackage

`default_nettype wire

// File: hdl/wave_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ram
	import wave_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  wr_en,
	input  wire logic [ram_addr_w-1:0] wr_addr,
	input  wire logic [sample_w-1:0]   wr_data,
	input  wire logic [ram_addr_w-1:0] rd_addr,
	output logic      [sample_w-1:0]   rd_data
);

	// One full waveform per channel
	logic [sample_w-1:0] mem [2**ram_addr_w];

	// Host write port
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, one cycle behind rd_addr
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
hdl/wave_pkg.sv
hdl/dac_pkg.sv
hdl/wave_ram.sv
hdl/limit_monitor.sv
hdl/wave_channel.sv
hdl/dac_set_regs.sv
hdl/dac_sync_gen.sv
hdl/dac_wave_top.sv
testbench/tb_dac_wave.sv

// File: testbench/tb_dac_model.svh
`ifndef TB_DAC_MODEL_SVH
`define TB_DAC_MODEL_SVH

// ----------------------------------------
// Host-side state
// ----------------------------------------

// Sample memory contents per channel
logic [sample_w-1:0] mem_model [n_ch][256];

// Static value per channel is 0 after reset
logic [dac_w-1:0] set_model [n_ch];

// DAC code of one stored sample is four LSB steps per sample step
function automatic logic [dac_w-1:0] exp_sample(input int ch, input int addr);
	return dac_w'(mem_model[ch][addr] * 4);
endfunction

// Any played code above the amplitude limit
function automatic logic exp_vol_err(input int ch, input int start, input int vmax);
	for (int a = start; a < 256; a++)
	begin
		if (int'(exp_sample(ch, a)) > vmax)
			return 1'b1;
	end
	return 1'b0;
endfunction

// Any step between neighbours above the slope limit
function automatic logic exp_slope_err(input int ch, input int start, input int smax);
	int diff;
	// First sample after start has no predecessor
	for (int a = start + 1; a < 256; a++)
	begin
		diff = int'(exp_sample(ch, a)) - int'(exp_sample(ch, a - 1));
		if (diff < 0)
			diff = -diff;
		if (diff > smax)
			return 1'b1;
	end
	return 1'b0;
endfunction

`endif

// File: testbench/tb_dac_wave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dac_wave
	import wave_pkg::*;
	import dac_pkg::*;
();

	localparam int n_ch    = 4;
	localparam int n_tests = 5;

	`include "tb_dac_model.svh"

	logic                             clk;
	logic                             rstn;
	logic [div_w-1:0]                 div_cnt;
	logic                             da_set_en;
	logic                             da_set_wren;
	logic [host_word_w-1:0]           set_word;
	logic [dac_w-1:0]                 vol_max;
	logic [slope_w-1:0]               slope_max;
	logic [n_ch-1:0]                  wave_req;
	logic [n_ch-1:0][ram_addr_w-1:0]  start_addr;
	logic [host_word_w-1:0]           wave_addr;
	logic [sample_w-1:0]              wave_data;
	logic                             wave_wren;
	logic [n_ch-1:0]                  wave_end;
	logic [n_ch-1:0]                  vol_err;
	logic [n_ch-1:0]                  slope_err;
	logic [n_ch-1:0]                  da_dclk;
	logic [n_ch-1:0][dac_w-1:0]       da_data;

	// Expected stream state per channel
	bit   [n_ch-1:0] play_on;
	bit   [n_ch-1:0] static_on;
	bit   [n_ch-1:0] last_ok;
	int              exp_pos    [n_ch];
	int              last_pulse [n_ch];
	int              pulse_cnt  [n_ch];
	int              cyc        = 0;
	int              tick_limit = 0;
	logic [n_ch-1:0][ram_addr_w-1:0] starts;

	dac_wave_top #(.n_ch(n_ch)) dut_i (.*);

	always #10 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ----------------------------------------
	// Reporting
	// ----------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, want);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	// One DAC load on channel ch
	task automatic check_pulse(input int ch);
		// Same slot every sample period
		if (last_ok[ch])
			check_value($sformatf("da_dclk[%0d] interval", ch), cyc - last_pulse[ch],
				div_cnt + 1);
		last_pulse[ch] = cyc;
		last_ok[ch]    = 1'b1;
		pulse_cnt[ch]++;
		if (play_on[ch])
		begin
			check_value($sformatf("da_data[%0d]", ch), da_data[ch], exp_sample(ch, exp_pos[ch]));
			check_value($sformatf("wave_end[%0d]", ch), wave_end[ch], exp_pos[ch] == 255);
			if (exp_pos[ch] == 255)
				play_on[ch] = 1'b0;
			else
				exp_pos[ch]++;
		end
		else if (static_on[ch])
		begin
			check_value($sformatf("da_data[%0d]", ch), da_data[ch], set_model[ch]);
			check_value($sformatf("wave_end[%0d]", ch), wave_end[ch], 1'b0);
		end
		else
			report_fail($sformatf("Channel %0d loaded its DAC while idle and not enabled", ch));
	endtask

	// Outputs settle after posedge and are sampled mid-cycle
	always @(negedge clk)
	begin
		if (rstn)
		begin
			// Phase slots keep loads apart
			if ($countones(da_dclk) > 1)
				report_fail("DAC loads of two channels landed on the same clock edge");
			for (int ch = 0; ch < n_ch; ch++)
			begin
				if (da_dclk[ch])
					check_pulse(ch);
				else
					check_value($sformatf("wave_end[%0d]", ch), wave_end[ch], 1'b0);
			end
		end
	end

	// ----------------------------------------
	// Host bus tasks enter and leave on negedge
	// ----------------------------------------
	task automatic write_sample(input int ch, input int addr, input logic [sample_w-1:0] data);
		wave_addr = host_word_w'((ch << chan_sel_lsb) | addr);
		wave_data = data;
		wave_wren = 1'b1;
		if (ch < n_ch)
			mem_model[ch][addr] = data;
		@(negedge clk);
		wave_wren = 1'b0;
	endtask

	task automatic write_set(input int ch, input int value);
		set_word    = host_word_w'((ch << chan_sel_lsb) | value);
		da_set_wren = 1'b1;
		// Out-of-range channels leave the model alone
		if (ch < n_ch)
			set_model[ch] = dac_w'(value);
		@(negedge clk);
		da_set_wren = 1'b0;
	endtask

	task automatic request_all(input logic [n_ch-1:0][ram_addr_w-1:0] addrs);
		start_addr = addrs;
		wave_req   = '1;
		for (int ch = 0; ch < n_ch; ch++)
		begin
			exp_pos[ch] = addrs[ch];
			play_on[ch] = 1'b1;
			last_ok[ch] = 1'b0;
		end
		@(negedge clk);
		wave_req = '0;
	endtask

	// Compare process drops play_on at each wave_end
	task automatic wait_idle();
		while (play_on != '0)
			@(negedge clk);
	endtask

	task automatic check_flags();
		for (int ch = 0; ch < n_ch; ch++)
		begin
			check_value($sformatf("vol_err[%0d]", ch), vol_err[ch],
				exp_vol_err(ch, starts[ch], vol_max));
			check_value($sformatf("slope_err[%0d]", ch), slope_err[ch],
				exp_slope_err(ch, starts[ch], slope_max));
		end
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial
	begin
		void'($urandom(75214));
		clk         = 1'b0;
		rstn        = 1'b0;
		da_set_en   = 1'b0;
		da_set_wren = 1'b0;
		set_word    = '0;
		wave_req    = '0;
		start_addr  = '0;
		wave_addr   = '0;
		wave_data   = '0;
		wave_wren   = '0;
		vol_max   = '1;
		slope_max = '1;
		div_cnt   = div_w'($urandom_range(8, 3));
		for (int ch = 0; ch < n_ch; ch++)
			set_model[ch] = '0;
		tick_limit = n_tests * (256 * (div_cnt + 1) + 100);
		repeat (16) @(negedge clk);
		rstn = 1'b1;
		@(negedge clk);

		// Test 1 checks quiet outputs after reset
		check_value("wave_end", wave_end, '0);
		check_value("vol_err", vol_err, '0);
		check_value("slope_err", slope_err, '0);
		check_value("da_dclk", da_dclk, '0);
		for (int ch = 0; ch < n_ch; ch++)
			check_value($sformatf("da_data[%0d]", ch), da_data[ch], '0);
		repeat (20 + 4 * (div_cnt + 1)) @(negedge clk);

		// Test 2 loads static values and ignores channels 4 to 7
		for (int ch = 0; ch < n_ch; ch++)
			write_set(ch, $urandom_range(1023, 0));
		for (int k = 0; k < 12; k++)
			write_set($urandom_range(7, 0), $urandom_range(1023, 0));
		last_ok   = '0;
		static_on = '1;
		for (int ch = 0; ch < n_ch; ch++)
			pulse_cnt[ch] = 0;
		da_set_en = 1'b1;
		repeat (5 * (div_cnt + 1)) @(negedge clk);
		da_set_en = 1'b0;
		// Loads still in the pipeline
		repeat (4) @(negedge clk);
		static_on = '0;
		for (int ch = 0; ch < n_ch; ch++)
			check_value($sformatf("da_dclk[%0d] count >= 4", ch), pulse_cnt[ch] >= 4, 1'b1);

		// Test 3 plays random memories from random starts within the limits
		for (int ch = 0; ch < n_ch; ch++)
			for (int a = 0; a < 256; a++)
				write_sample(ch, a, sample_w'($urandom));
		for (int k = 0; k < 8; k++)
			write_sample($urandom_range(63, n_ch), $urandom_range(255, 0), sample_w'($urandom));
		for (int ch = 0; ch < n_ch; ch++)
			starts[ch] = ram_addr_w'($urandom_range(255, 0));
		request_all(starts);
		wait_idle();
		check_flags();

		// Test 4 keeps random data on even channels and ramps on odd ones
		vol_max   = 700;
		slope_max = 300;
		for (int ch = 1; ch < n_ch; ch += 2)
			for (int a = 0; a < 256; a++)
				write_sample(ch, a, sample_w'(a / 4));
		for (int ch = 0; ch < n_ch; ch++)
			starts[ch] = ram_addr_w'($urandom_range(63, 0));
		request_all(starts);
		wait_idle();
		check_flags();
		// Flags drop with the next request
		for (int ch = 0; ch < n_ch; ch++)
			starts[ch] = 200;
		request_all(starts);
		check_value("vol_err", vol_err, '0);
		check_value("slope_err", slope_err, '0);
		wait_idle();
		check_flags();

		// Slot overlap and load interval of test 5 are checked at every load
		$display("all tests passed");
		$finish;
	end

	// Watchdog sized from the sample period
	initial
	begin
		wait (tick_limit > 0);
		repeat (tick_limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", tick_limit);
		$display("tests failed");
		$fatal(1);
	end

endmodule

`default_nettype wire
